// File: rnn_pkg.sv
package rnn_pkg;

    // Layer size
    localparam int HIDDEN_SIZE = 4;

    // Q16.16 fixed point
    localparam int DATA_W = 32;
    localparam int FRAC_W = 16;

    // Five guard bits cover the column sums without overflow
    localparam int ACC_W = DATA_W + 5;

    typedef logic signed [DATA_W-1:0] fixed_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef fixed_t [HIDDEN_SIZE-1:0] hidden_vec_t;

    // Saturation limits
    localparam fixed_t FIXED_MAX = fixed_t'({1'b0, {(DATA_W-1){1'b1}}});
    localparam fixed_t FIXED_MIN = fixed_t'({1'b1, {(DATA_W-1){1'b0}}});

    // Input to hidden, one weight per hidden unit
    localparam fixed_t W_I2H [HIDDEN_SIZE] = '{
        32'sh0002_8000,   // 2.5
        32'shFFFD_C000,   // -2.25
        32'sh0000_C000,   // 0.75
        32'sh0003_0000    // 3.0
    };

    // Hidden to hidden, row is the source element, column the destination unit
    localparam fixed_t W_H2H [HIDDEN_SIZE][HIDDEN_SIZE] = '{
        '{32'sh0000_8000, 32'shFFFF_C000, 32'sh0000_2000, 32'sh0000_199A},
        '{32'shFFFF_B333, 32'sh0000_6000, 32'shFFFF_8000, 32'sh0000_4000},
        '{32'sh0000_1000, 32'shFFFF_E000, 32'sh0000_5000, 32'shFFFF_A000},
        '{32'sh0000_3000, 32'sh0000_199A, 32'shFFFF_F000, 32'sh0000_6666}
    };

    // Hidden to output
    localparam fixed_t W_H2O [HIDDEN_SIZE] = '{
        32'sh0001_8000,   // 1.5
        32'shFFFF_4000,   // -0.75
        32'sh0000_A000,   // 0.625
        32'shFFFE_C000    // -1.25
    };

    // Full signed product, rescaled and truncated to one word
    function automatic fixed_t fixed_mul(
        input fixed_t a,
        input fixed_t b
    );
        logic signed [2*DATA_W-1:0] prod;

        prod = a * b;
        return fixed_t'(prod >>> FRAC_W);
    endfunction

endpackage

// File: rnn_recurrent_matvec.sv
module rnn_recurrent_matvec (
    input  rnn_pkg::hidden_vec_t i_hidden,
    output rnn_pkg::hidden_vec_t o_recurrent
);

    // One product per weight, indexed [source][destination]
    rnn_pkg::fixed_t partial [rnn_pkg::HIDDEN_SIZE][rnn_pkg::HIDDEN_SIZE];

    rnn_pkg::acc_t col_sum [rnn_pkg::HIDDEN_SIZE];

    genvar gi;
    genvar gj;

    generate
        for (gi = 0; gi < rnn_pkg::HIDDEN_SIZE; gi++) begin : g_row
            for (gj = 0; gj < rnn_pkg::HIDDEN_SIZE; gj++) begin : g_col
                assign partial[gi][gj] = rnn_pkg::fixed_mul(i_hidden[gi],
                                                            rnn_pkg::W_H2H[gi][gj]);
            end
        end
    endgenerate

    // Column sums in the wide accumulator
    generate
        for (gj = 0; gj < rnn_pkg::HIDDEN_SIZE; gj++) begin : g_sum
            always_comb begin
                rnn_pkg::acc_t acc;

                acc = '0;
                for (int i = 0; i < rnn_pkg::HIDDEN_SIZE; i++) begin
                    acc = acc + rnn_pkg::acc_t'(partial[i][gj]);
                end
                col_sum[gj] = acc;
            end

            // Low word only, an overflowing sum wraps
            assign o_recurrent[gj] = rnn_pkg::fixed_t'(col_sum[gj][rnn_pkg::DATA_W-1:0]);
        end
    endgenerate

endmodule

// File: rnn_hidden_update.sv
module rnn_hidden_update (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_valid,
    input  rnn_pkg::fixed_t      i_x,
    input  rnn_pkg::hidden_vec_t i_recurrent,
    output rnn_pkg::hidden_vec_t o_hidden,
    output logic                 o_step_done
);

    localparam int SUM_W = rnn_pkg::DATA_W + 1;

    // Saturating sum, visible before the register
    rnn_pkg::hidden_vec_t hidden_next;

    genvar gu;

    generate
        for (gu = 0; gu < rnn_pkg::HIDDEN_SIZE; gu++) begin : g_unit
            rnn_pkg::fixed_t        input_term;
            rnn_pkg::fixed_t        rec_term;
            logic signed [SUM_W-1:0] sum_ext;

            assign input_term = rnn_pkg::fixed_mul(i_x, rnn_pkg::W_I2H[gu]);
            assign rec_term   = i_recurrent[gu];

            // One extra sign bit is enough for a two-term sum
            assign sum_ext = {rec_term[rnn_pkg::DATA_W-1], rec_term}
                           + {input_term[rnn_pkg::DATA_W-1], input_term};

            always_comb begin
                if (sum_ext > SUM_W'(rnn_pkg::FIXED_MAX)) begin
                    hidden_next[gu] = rnn_pkg::FIXED_MAX;
                end else if (sum_ext < $signed(SUM_W'(rnn_pkg::FIXED_MIN))) begin
                    hidden_next[gu] = rnn_pkg::FIXED_MIN;
                end else begin
                    hidden_next[gu] = sum_ext[rnn_pkg::DATA_W-1:0];
                end
            end
        end
    endgenerate

    // Hidden state register, updated only on an accepted step
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_hidden    <= '0;
            o_step_done <= 1'b0;
        end else begin
            o_step_done <= i_valid;
            if (i_valid) begin
                o_hidden <= hidden_next;
            end
        end
    end

endmodule

// File: rnn_output_reduce.sv
module rnn_output_reduce (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_step_done,
    input  rnn_pkg::hidden_vec_t i_hidden,
    output logic                 o_valid,
    output rnn_pkg::fixed_t      o_y
);

    // Weighted hidden elements
    rnn_pkg::fixed_t partial [rnn_pkg::HIDDEN_SIZE];

    rnn_pkg::acc_t   dot_acc;
    rnn_pkg::fixed_t y_next;

    genvar gk;

    generate
        for (gk = 0; gk < rnn_pkg::HIDDEN_SIZE; gk++) begin : g_mul
            assign partial[gk] = rnn_pkg::fixed_mul(i_hidden[gk], rnn_pkg::W_H2O[gk]);
        end
    endgenerate

    // Reduction tree left to synthesis
    always_comb begin
        dot_acc = '0;
        for (int k = 0; k < rnn_pkg::HIDDEN_SIZE; k++) begin
            dot_acc = dot_acc + rnn_pkg::acc_t'(partial[k]);
        end
    end

    // Wraps to one word like the recurrent sums
    assign y_next = rnn_pkg::fixed_t'(dot_acc[rnn_pkg::DATA_W-1:0]);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
            o_y     <= '0;
        end else begin
            o_valid <= i_step_done;
            if (i_step_done) begin
                o_y <= y_next;
            end
        end
    end

endmodule

// File: rnn_cell.sv
module rnn_cell (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_valid,
    input  rnn_pkg::fixed_t      i_x,
    output rnn_pkg::hidden_vec_t o_hidden,
    output logic                 o_valid,
    output rnn_pkg::fixed_t      o_y
);

    // Registered hidden state, shared by the recurrence and the output
    rnn_pkg::hidden_vec_t hidden_state;

    // Combinational recurrent projection of the current state
    rnn_pkg::hidden_vec_t recurrent;

    logic step_done;

    rnn_recurrent_matvec rnn_recurrent_matvec_i (
        .i_hidden    (hidden_state),
        .o_recurrent (recurrent)
    );

    rnn_hidden_update rnn_hidden_update_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_valid     (i_valid),
        .i_x         (i_x),
        .i_recurrent (recurrent),
        .o_hidden    (hidden_state),
        .o_step_done (step_done)
    );

    // Output follows the hidden update by one cycle
    rnn_output_reduce rnn_output_reduce_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_step_done (step_done),
        .i_hidden    (hidden_state),
        .o_valid     (o_valid),
        .o_y         (o_y)
    );

    assign o_hidden = hidden_state;

endmodule

// File: rnn_cell_model.svh
`ifndef RNN_CELL_MODEL_SVH
`define RNN_CELL_MODEL_SVH

// Q16.16 product from the 64-bit signed product, rescaled, low word kept
function automatic rnn_pkg::fixed_t product_q16(input rnn_pkg::fixed_t a,
                                                input rnn_pkg::fixed_t b);
    longint full;

    full = longint'(a) * longint'(b);
    return rnn_pkg::fixed_t'(full >>> rnn_pkg::FRAC_W);
endfunction

// Next hidden vector: wrapped column sums plus the input term, then clamped
function automatic rnn_pkg::hidden_vec_t hidden_next(input rnn_pkg::hidden_vec_t prev,
                                                     input rnn_pkg::fixed_t x);
    rnn_pkg::hidden_vec_t nxt;
    rnn_pkg::fixed_t      rec;
    longint               col;
    longint               total;

    for (int j = 0; j < rnn_pkg::HIDDEN_SIZE; j++) begin
        col = 0;
        for (int i = 0; i < rnn_pkg::HIDDEN_SIZE; i++) begin
            col += longint'(product_q16(prev[i], rnn_pkg::W_H2H[i][j]));
        end
        rec   = rnn_pkg::fixed_t'(col);
        total = longint'(rec) + longint'(product_q16(x, rnn_pkg::W_I2H[j]));
        if (total > longint'(rnn_pkg::FIXED_MAX)) begin
            nxt[j] = rnn_pkg::FIXED_MAX;
        end else if (total < longint'(rnn_pkg::FIXED_MIN)) begin
            nxt[j] = rnn_pkg::FIXED_MIN;
        end else begin
            nxt[j] = rnn_pkg::fixed_t'(total);
        end
    end
    return nxt;
endfunction

// Output scalar, wrapped to one word
function automatic rnn_pkg::fixed_t output_of(input rnn_pkg::hidden_vec_t h);
    longint acc;

    acc = 0;
    for (int k = 0; k < rnn_pkg::HIDDEN_SIZE; k++) begin
        acc += longint'(product_q16(h[k], rnn_pkg::W_H2O[k]));
    end
    return rnn_pkg::fixed_t'(acc);
endfunction

`endif

// File: rnn_cell_tb.sv
module rnn_cell_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 40;
    localparam int MAX_GAP      = 3;
    localparam int IDLE_GAP     = 5;
    localparam int EXTREME_IDLE = 3;
    localparam int DRAIN        = 4;
    localparam int STIM_CYCLES  = RESET_CYCLES + NUM_RANDOM * (1 + MAX_GAP) + IDLE_GAP
                                + 2 * (RESET_CYCLES + 2 + EXTREME_IDLE) + DRAIN;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 20;

    // +10000.0 and -10000.0, two such steps after a reset saturate some units
    localparam rnn_pkg::fixed_t X_POS_BIG = 32'sh2710_0000;
    localparam rnn_pkg::fixed_t X_NEG_BIG = 32'shD8F0_0000;

    logic                 i_clk;
    logic                 i_reset;
    logic                 i_valid;
    rnn_pkg::fixed_t      i_x;
    rnn_pkg::hidden_vec_t o_hidden;
    logic                 o_valid;
    rnn_pkg::fixed_t      o_y;

    // Scoreboard state
    rnn_pkg::hidden_vec_t model_hidden;
    rnn_pkg::fixed_t      exp_y;
    rnn_pkg::fixed_t      y_queue[$];
    logic                 exp_valid;
    logic                 step_pending;
    int                   steps_seen;
    int                   idle_run;
    int                   cycle_count;
    logic                 sat_max_seen;
    logic                 sat_min_seen;
    logic [15:0]          lfsr_state;

    `include "rnn_cell_model.svh"

    rnn_cell rnn_cell_i (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_valid  (i_valid),
        .i_x      (i_x),
        .o_hidden (o_hidden),
        .o_valid  (o_valid),
        .o_y      (o_y)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int b = 0; b < n; b++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Every drive happens 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic send_step(input rnn_pkg::fixed_t x);
        i_valid = 1'b1;
        i_x     = x;
        next_cycle();
        i_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        i_valid = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic apply_reset();
        i_reset = 1'b1;
        i_valid = 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        i_reset = 1'b0;
    endtask

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run("run did not finish within the cycle limit");
        end
    end

    always @(posedge i_clk) begin
        if (i_reset) begin
            model_hidden = '0;
            exp_valid    = 1'b0;
            exp_y        = '0;
            step_pending = 1'b0;
            steps_seen   = 0;
            idle_run     = 0;
            y_queue.delete();
        end else begin
            exp_valid = step_pending;
            if (step_pending) begin
                exp_y = y_queue.pop_front();
            end
            step_pending = i_valid;
            if (i_valid) begin
                model_hidden = hidden_next(model_hidden, i_x);
                y_queue.push_back(output_of(model_hidden));
                for (int u = 0; u < rnn_pkg::HIDDEN_SIZE; u++) begin
                    sat_max_seen |= (model_hidden[u] == rnn_pkg::FIXED_MAX);
                    sat_min_seen |= (model_hidden[u] == rnn_pkg::FIXED_MIN);
                end
                steps_seen++;
                idle_run = 0;
            end else begin
                idle_run++;
            end
        end
    end

    a_after_reset: assert property (@(posedge i_clk) disable iff (i_reset)
        (steps_seen == 0) |-> (!o_valid && o_hidden == '0 && o_y == '0))
        else fail_run($sformatf("mismatch after reset o_valid %h o_hidden %h o_y %h",
                                $sampled(o_valid), $sampled(o_hidden), $sampled(o_y)));

    a_hidden: assert property (@(posedge i_clk) disable iff (i_reset)
        o_hidden == model_hidden)
        else fail_run($sformatf("mismatch o_hidden got %h expected %h",
                                $sampled(o_hidden), $sampled(model_hidden)));

    a_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        o_valid == exp_valid)
        else fail_run($sformatf("mismatch o_valid got %h expected %h",
                                $sampled(o_valid), $sampled(exp_valid)));

    a_y: assert property (@(posedge i_clk) disable iff (i_reset)
        o_y == exp_y)
        else fail_run($sformatf("mismatch o_y got %h expected %h",
                                $sampled(o_y), $sampled(exp_y)));

    // Two idle edges in a row leave both registers untouched
    a_idle_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        (idle_run >= 2) |-> (o_hidden == $past(o_hidden) && o_y == $past(o_y) && !o_valid))
        else fail_run($sformatf("mismatch idle o_hidden %h o_y %h o_valid %h",
                                $sampled(o_hidden), $sampled(o_y), $sampled(o_valid)));

    initial begin
        logic [31:0] bits;

        i_reset      = 1'b1;
        i_valid      = 1'b0;
        i_x          = '0;
        cycle_count  = 0;
        sat_max_seen = 1'b0;
        sat_min_seen = 1'b0;
        lfsr_state   = 16'd81;

        apply_reset();

        for (int n = 0; n < NUM_RANDOM; n++) begin
            take_bits(19, bits);
            // 19 random bits centred on zero span -4.0 to +4.0
            send_step(rnn_pkg::fixed_t'(bits) - 32'sh0004_0000);
            take_bits(2, bits);
            if (bits[1:0] >= 2) begin
                idle_cycles(int'(bits[1:0]) - 1);
            end
        end
        idle_cycles(IDLE_GAP);

        apply_reset();
        send_step(X_POS_BIG);
        send_step(X_POS_BIG);
        idle_cycles(EXTREME_IDLE);

        apply_reset();
        send_step(X_NEG_BIG);
        send_step(X_NEG_BIG);
        idle_cycles(EXTREME_IDLE);

        idle_cycles(DRAIN);

        if (!sat_max_seen || !sat_min_seen) begin
            fail_run("the hidden state never reached both saturation limits");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: rnn_cell.f
+incdir+.
rnn_pkg.sv
rnn_recurrent_matvec.sv
rnn_hidden_update.sv
rnn_output_reduce.sv
rnn_cell.sv
rnn_cell_tb.sv
